// ==== arm_params.svh ====
`ifndef ARM_PARAMS_SVH
`define ARM_PARAMS_SVH

`define ARM_XLEN        32
`define ARM_NREGS       15
`define ARM_RW          4
`define ARM_PC_RESET    32'h0000_0000

// Data-processing opcodes
`define ARM_OP_AND      4'h0
`define ARM_OP_EOR      4'h1
`define ARM_OP_SUB      4'h2
`define ARM_OP_RSB      4'h3
`define ARM_OP_ADD      4'h4
`define ARM_OP_ADC      4'h5
`define ARM_OP_SBC      4'h6
`define ARM_OP_RSC      4'h7
`define ARM_OP_TST      4'h8
`define ARM_OP_TEQ      4'h9
`define ARM_OP_CMP      4'ha
`define ARM_OP_CMN      4'hb
`define ARM_OP_ORR      4'hc
`define ARM_OP_MOV      4'hd
`define ARM_OP_BIC      4'he
`define ARM_OP_MVN      4'hf

// Condition field
`define ARM_COND_EQ     4'h0
`define ARM_COND_NE     4'h1
`define ARM_COND_CS     4'h2
`define ARM_COND_CC     4'h3
`define ARM_COND_MI     4'h4
`define ARM_COND_PL     4'h5
`define ARM_COND_VS     4'h6
`define ARM_COND_VC     4'h7
`define ARM_COND_HI     4'h8
`define ARM_COND_LS     4'h9
`define ARM_COND_GE     4'ha
`define ARM_COND_LT     4'hb
`define ARM_COND_GT     4'hc
`define ARM_COND_LE     4'hd
`define ARM_COND_AL     4'he

`endif

// ==== arm_pkg.sv ====
`include "arm_params.svh"

package arm_pkg;

    // One instruction word, two decodings
    typedef union packed {
        struct packed {
            logic [3:0]             cond;
            logic [1:0]             cls;
            logic                   i;
            logic [3:0]             opcode;
            logic                   s;
            logic [`ARM_RW-1:0]     rn;
            logic [`ARM_RW-1:0]     rd;
            logic [11:0]            operand2;
        } dp;
        struct packed {
            logic [3:0]             cond;
            logic [1:0]             cls;
            logic                   i;
            logic                   p;
            logic                   u;
            logic                   b;
            logic                   w;
            logic                   l;
            logic [`ARM_RW-1:0]     rn;
            logic [`ARM_RW-1:0]     rd;
            logic [11:0]            offset12;
        } mem;
    } inst_u;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    // Decode to execute
    typedef struct packed {
        logic [`ARM_XLEN-1:0]       op_a;
        logic [`ARM_XLEN-1:0]       op_b;
        logic [3:0]                 opcode;
        logic                       set_flags;
        logic [`ARM_RW-1:0]         rd;
        logic                       rd_we;
        logic                       is_load;
        logic                       is_store;
        logic [`ARM_XLEN-1:0]       store_data;
        logic                       mem_up;
    } dec_t;

    // Execute to write-back
    typedef struct packed {
        logic                       we;
        logic [`ARM_RW-1:0]         rd;
        logic                       from_mem;
        logic [`ARM_XLEN-1:0]       result;
    } wb_t;

    // Register write in flight
    typedef struct packed {
        logic                       we;
        logic [`ARM_RW-1:0]         rd;
        logic [`ARM_XLEN-1:0]       value;
    } fwd_src_t;

endpackage

// ==== arm_fetch.sv ====
`timescale 1ns/1ps
`include "arm_params.svh"

module arm_fetch (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_en,
    input  logic                    i_stall,
    input  logic                    i_redirect,
    input  logic [`ARM_XLEN-1:0]    i_target,
    output logic                    o_rom_en,
    output logic [`ARM_XLEN-1:0]    o_rom_addr,
    output logic [`ARM_XLEN-1:0]    o_pc_id
);

    logic [`ARM_XLEN-1:0] pc;

    assign o_rom_en = i_en;

    // Stalled word is fetched again so decode sees it next cycle
    assign o_rom_addr = i_stall ? o_pc_id : pc;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc      <= `ARM_PC_RESET;
            o_pc_id <= `ARM_PC_RESET;
        end else if (i_en && !i_stall) begin
            o_pc_id <= pc;
            if (i_redirect) begin
                pc <= i_target;
            end else begin
                pc <= pc + `ARM_XLEN'd4;
            end
        end
    end

endmodule

// ==== arm_regfile.sv ====
`timescale 1ns/1ps
`include "arm_params.svh"

module arm_regfile (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic [`ARM_RW-1:0]      i_ra,
    input  logic [`ARM_RW-1:0]      i_rb,
    input  logic [`ARM_RW-1:0]      i_rc,
    output logic [`ARM_XLEN-1:0]    o_a,
    output logic [`ARM_XLEN-1:0]    o_b,
    output logic [`ARM_XLEN-1:0]    o_c,
    input  arm_pkg::fwd_src_t       i_wr
);

    logic [`ARM_XLEN-1:0] regs [`ARM_NREGS];

    // Code 15 has no register behind it
    assign o_a = (i_ra < `ARM_NREGS) ? regs[i_ra] : '0;
    assign o_b = (i_rb < `ARM_NREGS) ? regs[i_rb] : '0;
    assign o_c = (i_rc < `ARM_NREGS) ? regs[i_rc] : '0;

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int k = 0; k < `ARM_NREGS; k++) begin
                regs[k] <= '0;
            end
        end else if (i_wr.we && i_wr.rd < `ARM_NREGS) begin
            regs[i_wr.rd] <= i_wr.value;
        end
    end

endmodule

// ==== arm_decode.sv ====
`timescale 1ns/1ps
`include "arm_params.svh"

module arm_decode (
    input  logic                    i_vld,
    input  arm_pkg::inst_u          i_inst,
    input  logic [`ARM_XLEN-1:0]    i_pc,
    input  arm_pkg::flags_t         i_flags,
    output logic [`ARM_RW-1:0]      o_ra,
    output logic [`ARM_RW-1:0]      o_rb,
    output logic [`ARM_RW-1:0]      o_rc,
    output logic                    o_use_a,
    output logic                    o_use_b,
    output logic                    o_use_c,
    input  logic [`ARM_XLEN-1:0]    i_a,
    input  logic [`ARM_XLEN-1:0]    i_b,
    input  logic [`ARM_XLEN-1:0]    i_c,
    output arm_pkg::dec_t           o_dec,
    output logic                    o_redirect,
    output logic [`ARM_XLEN-1:0]    o_target
);

    logic                   is_dp;
    logic                   is_mem;
    logic                   is_br;
    logic                   is_cmp;
    logic                   is_mov;
    logic                   rd_we;
    logic                   bad_reg;
    logic                   ok;
    logic [2*`ARM_XLEN-1:0] rot;
    logic [23:0]            br_off;

    function automatic logic cond_pass(input logic [3:0] cond, input arm_pkg::flags_t f);
        case (cond)
            `ARM_COND_EQ: return f.z;
            `ARM_COND_NE: return !f.z;
            `ARM_COND_CS: return f.c;
            `ARM_COND_CC: return !f.c;
            `ARM_COND_MI: return f.n;
            `ARM_COND_PL: return !f.n;
            `ARM_COND_VS: return f.v;
            `ARM_COND_VC: return !f.v;
            `ARM_COND_HI: return f.c && !f.z;
            `ARM_COND_LS: return !f.c || f.z;
            `ARM_COND_GE: return f.n == f.v;
            `ARM_COND_LT: return f.n != f.v;
            `ARM_COND_GT: return !f.z && (f.n == f.v);
            `ARM_COND_LE: return f.z || (f.n != f.v);
            `ARM_COND_AL: return 1'b1;
            default:      return 1'b0;
        endcase
    endfunction

    // Instruction class
    // --------------------
    // Compares without S are MRS/MSR space, shifted registers are not kept
    assign is_cmp = i_inst.dp.opcode[3:2] == 2'b10;
    assign is_mov = i_inst.dp.opcode[3:2] == 2'b11 && i_inst.dp.opcode[0];
    assign is_dp  = i_inst.dp.cls == 2'b00
                  && (i_inst.dp.i || i_inst.dp.operand2[11:4] == 8'h00)
                  && !(is_cmp && !i_inst.dp.s);
    assign is_mem = i_inst.mem.cls == 2'b01 && !i_inst.mem.i && i_inst.mem.p
                  && !i_inst.mem.b && !i_inst.mem.w;
    assign is_br  = i_inst.dp.cls == 2'b10 && i_inst.dp.i && !i_inst.dp.opcode[3];

    // Register reads
    // --------------------
    assign o_ra    = i_inst.dp.rn;
    assign o_rb    = i_inst.dp.operand2[`ARM_RW-1:0];
    assign o_rc    = i_inst.dp.rd;
    assign o_use_a = i_vld && ((is_dp && !is_mov) || is_mem);
    assign o_use_b = i_vld && is_dp && !i_inst.dp.i;
    assign o_use_c = i_vld && is_mem && !i_inst.mem.l;

    assign rd_we   = (is_dp && !is_cmp) || (is_mem && i_inst.mem.l);
    assign bad_reg = (o_use_a && o_ra == 4'hf) || (o_use_b && o_rb == 4'hf)
                   || ((rd_we || o_use_c) && o_rc == 4'hf);
    assign ok      = i_vld && cond_pass(i_inst.dp.cond, i_flags) && !bad_reg;

    // Immediate rotated right by twice the 4-bit field
    assign rot = {24'h0, i_inst.dp.operand2[7:0], 24'h0, i_inst.dp.operand2[7:0]}
                 >> {i_inst.dp.operand2[11:8], 1'b0};

    always_comb begin
        o_dec = '0;
        if (ok && (is_dp || is_mem)) begin
            o_dec.op_a       = i_a;
            if (is_mem) begin
                o_dec.op_b = {20'h0, i_inst.mem.offset12};
            end else if (i_inst.dp.i) begin
                o_dec.op_b = rot[`ARM_XLEN-1:0];
            end else begin
                o_dec.op_b = i_b;
            end
            o_dec.opcode     = i_inst.dp.opcode;
            o_dec.set_flags  = is_dp && i_inst.dp.s;
            o_dec.rd         = i_inst.dp.rd;
            o_dec.rd_we      = rd_we;
            o_dec.is_load    = is_mem && i_inst.mem.l;
            o_dec.is_store   = is_mem && !i_inst.mem.l;
            o_dec.store_data = i_c;
            o_dec.mem_up     = i_inst.mem.u;
        end
    end

    // Branch, pc + 8 + offset * 4
    assign br_off     = i_inst[23:0];
    assign o_redirect = ok && is_br;
    assign o_target   = i_pc + `ARM_XLEN'd8 + {{6{br_off[23]}}, br_off, 2'b00};

endmodule

// ==== arm_hazard_fwd.sv ====
`timescale 1ns/1ps
`include "arm_params.svh"

module arm_hazard_fwd (
    input  logic [`ARM_RW-1:0]      i_ra,
    input  logic [`ARM_RW-1:0]      i_rb,
    input  logic [`ARM_RW-1:0]      i_rc,
    input  logic                    i_use_a,
    input  logic                    i_use_b,
    input  logic                    i_use_c,
    input  logic [`ARM_XLEN-1:0]    i_reg_a,
    input  logic [`ARM_XLEN-1:0]    i_reg_b,
    input  logic [`ARM_XLEN-1:0]    i_reg_c,
    input  arm_pkg::fwd_src_t       i_ex,
    input  logic                    i_ex_load,
    input  arm_pkg::fwd_src_t       i_wb,
    output logic [`ARM_XLEN-1:0]    o_a,
    output logic [`ARM_XLEN-1:0]    o_b,
    output logic [`ARM_XLEN-1:0]    o_c,
    output logic                    o_stall
);

    function automatic logic hit(input logic [`ARM_RW-1:0] code, input arm_pkg::fwd_src_t src);
        return src.we && src.rd == code;
    endfunction

    // Newest write wins
    function automatic logic [`ARM_XLEN-1:0] pick(
        input logic [`ARM_RW-1:0]   code,
        input logic [`ARM_XLEN-1:0] rf,
        input arm_pkg::fwd_src_t    ex,
        input arm_pkg::fwd_src_t    wb
    );
        if (hit(code, ex)) begin
            return ex.value;
        end
        if (hit(code, wb)) begin
            return wb.value;
        end
        return rf;
    endfunction

    assign o_a = pick(i_ra, i_reg_a, i_ex, i_wb);
    assign o_b = pick(i_rb, i_reg_b, i_ex, i_wb);
    assign o_c = pick(i_rc, i_reg_c, i_ex, i_wb);

    // Load data is not there until write-back
    assign o_stall = i_ex_load && ((i_use_a && hit(i_ra, i_ex))
                                || (i_use_b && hit(i_rb, i_ex))
                                || (i_use_c && hit(i_rc, i_ex)));

endmodule

// ==== arm_execute.sv ====
`timescale 1ns/1ps
`include "arm_params.svh"

module arm_execute (
    input  arm_pkg::dec_t           i_dec,
    input  arm_pkg::flags_t         i_flags,
    output arm_pkg::flags_t         o_flags_next,
    output arm_pkg::wb_t            o_wb,
    output logic                    o_ram_en,
    output logic                    o_ram_wr,
    output logic [`ARM_XLEN-1:0]    o_ram_addr,
    output logic [`ARM_XLEN-1:0]    o_ram_wdata
);

    logic [`ARM_XLEN-1:0]   x;
    logic [`ARM_XLEN-1:0]   y;
    logic [`ARM_XLEN-1:0]   lres;
    logic [`ARM_XLEN-1:0]   res;
    logic [`ARM_XLEN:0]     sum;
    logic                   cin;
    logic                   arith;
    arm_pkg::flags_t        alu_flags;

    // ALU
    // --------------------
    // Every arithmetic opcode is x + y + cin on the adder
    always_comb begin
        x     = i_dec.op_a;
        y     = i_dec.op_b;
        cin   = 1'b0;
        arith = 1'b0;
        lres  = '0;
        case (i_dec.opcode)
            `ARM_OP_AND, `ARM_OP_TST: lres = i_dec.op_a & i_dec.op_b;
            `ARM_OP_EOR, `ARM_OP_TEQ: lres = i_dec.op_a ^ i_dec.op_b;
            `ARM_OP_ORR:              lres = i_dec.op_a | i_dec.op_b;
            `ARM_OP_MOV:              lres = i_dec.op_b;
            `ARM_OP_BIC:              lres = i_dec.op_a & ~i_dec.op_b;
            `ARM_OP_MVN:              lres = ~i_dec.op_b;
            `ARM_OP_ADD, `ARM_OP_CMN: arith = 1'b1;
            `ARM_OP_ADC: begin
                arith = 1'b1;
                cin   = i_flags.c;
            end
            `ARM_OP_SUB, `ARM_OP_CMP: begin
                arith = 1'b1;
                y     = ~i_dec.op_b;
                cin   = 1'b1;
            end
            `ARM_OP_SBC: begin
                arith = 1'b1;
                y     = ~i_dec.op_b;
                cin   = i_flags.c;
            end
            `ARM_OP_RSB: begin
                arith = 1'b1;
                x     = ~i_dec.op_a;
                cin   = 1'b1;
            end
            `ARM_OP_RSC: begin
                arith = 1'b1;
                x     = ~i_dec.op_a;
                cin   = i_flags.c;
            end
        endcase
    end

    assign sum = {1'b0, x} + {1'b0, y} + {{`ARM_XLEN{1'b0}}, cin};
    assign res = arith ? sum[`ARM_XLEN-1:0] : lres;

    // Logical opcodes leave C and V alone
    always_comb begin
        alu_flags   = i_flags;
        alu_flags.n = res[`ARM_XLEN-1];
        alu_flags.z = res == '0;
        if (arith) begin
            alu_flags.c = sum[`ARM_XLEN];
            alu_flags.v = (x[`ARM_XLEN-1] == y[`ARM_XLEN-1])
                        && (sum[`ARM_XLEN-1] != x[`ARM_XLEN-1]);
        end
    end

    assign o_flags_next = i_dec.set_flags ? alu_flags : i_flags;

    assign o_wb.we       = i_dec.rd_we;
    assign o_wb.rd       = i_dec.rd;
    assign o_wb.from_mem = i_dec.is_load;
    assign o_wb.result   = res;

    // RAM request
    assign o_ram_en    = i_dec.is_load || i_dec.is_store;
    assign o_ram_wr    = i_dec.is_store;
    assign o_ram_addr  = i_dec.mem_up ? i_dec.op_a + i_dec.op_b : i_dec.op_a - i_dec.op_b;
    assign o_ram_wdata = i_dec.store_data;

endmodule

// ==== arm_core.sv ====
`timescale 1ns/1ps
`include "arm_params.svh"

module arm_core (
    input  logic                    clk,
    input  logic                    i_arst_n,
    input  logic                    i_en,

    output logic                    o_rom_en,
    output logic [`ARM_XLEN-1:0]    o_rom_addr,
    input  logic [`ARM_XLEN-1:0]    i_rom_data,

    output logic                    o_ram_en,
    output logic                    o_ram_wr,
    output logic [`ARM_XLEN-1:0]    o_ram_addr,
    input  logic [`ARM_XLEN-1:0]    i_ram_rdata,
    output logic [`ARM_XLEN-1:0]    o_ram_wdata
);

    logic                   id_vld;
    logic [`ARM_XLEN-1:0]   pc_id;
    arm_pkg::inst_u         id_inst;
    logic                   stall;
    logic                   redirect;
    logic [`ARM_XLEN-1:0]   target;
    logic [`ARM_RW-1:0]     ra;
    logic [`ARM_RW-1:0]     rb;
    logic [`ARM_RW-1:0]     rc;
    logic                   use_a;
    logic                   use_b;
    logic                   use_c;
    logic [`ARM_XLEN-1:0]   reg_a;
    logic [`ARM_XLEN-1:0]   reg_b;
    logic [`ARM_XLEN-1:0]   reg_c;
    logic [`ARM_XLEN-1:0]   fwd_a;
    logic [`ARM_XLEN-1:0]   fwd_b;
    logic [`ARM_XLEN-1:0]   fwd_c;
    arm_pkg::dec_t          dec_d;
    arm_pkg::dec_t          ex_q;
    arm_pkg::wb_t           ex_wb_d;
    arm_pkg::wb_t           wb_q;
    arm_pkg::flags_t        flags_q;
    arm_pkg::flags_t        flags_next;
    arm_pkg::fwd_src_t      ex_src;
    arm_pkg::fwd_src_t      wb_src;
    arm_pkg::fwd_src_t      rf_wr;
    logic                   ex_ram_en;
    logic                   ex_ram_wr;

    assign id_inst = i_rom_data;

    arm_fetch fetch_0 (
        .clk        (clk        ),
        .i_arst_n   (i_arst_n   ),
        .i_en       (i_en       ),
        .i_stall    (stall      ),
        .i_redirect (redirect   ),
        .i_target   (target     ),
        .o_rom_en   (o_rom_en   ),
        .o_rom_addr (o_rom_addr ),
        .o_pc_id    (pc_id      )
    );

    arm_regfile regfile_0 (
        .clk        (clk        ),
        .i_arst_n   (i_arst_n   ),
        .i_ra       (ra         ),
        .i_rb       (rb         ),
        .i_rc       (rc         ),
        .o_a        (reg_a      ),
        .o_b        (reg_b      ),
        .o_c        (reg_c      ),
        .i_wr       (rf_wr      )
    );

    arm_decode decode_0 (
        .i_vld      (id_vld     ),
        .i_inst     (id_inst    ),
        .i_pc       (pc_id      ),
        .i_flags    (flags_next ),
        .o_ra       (ra         ),
        .o_rb       (rb         ),
        .o_rc       (rc         ),
        .o_use_a    (use_a      ),
        .o_use_b    (use_b      ),
        .o_use_c    (use_c      ),
        .i_a        (fwd_a      ),
        .i_b        (fwd_b      ),
        .i_c        (fwd_c      ),
        .o_dec      (dec_d      ),
        .o_redirect (redirect   ),
        .o_target   (target     )
    );

    arm_hazard_fwd hazard_fwd_0 (
        .i_ra       (ra         ),
        .i_rb       (rb         ),
        .i_rc       (rc         ),
        .i_use_a    (use_a      ),
        .i_use_b    (use_b      ),
        .i_use_c    (use_c      ),
        .i_reg_a    (reg_a      ),
        .i_reg_b    (reg_b      ),
        .i_reg_c    (reg_c      ),
        .i_ex       (ex_src     ),
        .i_ex_load  (ex_q.is_load),
        .i_wb       (wb_src     ),
        .o_a        (fwd_a      ),
        .o_b        (fwd_b      ),
        .o_c        (fwd_c      ),
        .o_stall    (stall      )
    );

    arm_execute execute_0 (
        .i_dec        (ex_q       ),
        .i_flags      (flags_q    ),
        .o_flags_next (flags_next ),
        .o_wb         (ex_wb_d    ),
        .o_ram_en     (ex_ram_en  ),
        .o_ram_wr     (ex_ram_wr  ),
        .o_ram_addr   (o_ram_addr ),
        .o_ram_wdata  (o_ram_wdata)
    );

    // Memory strobes only in enabled cycles
    assign o_ram_en = ex_ram_en & i_en;
    assign o_ram_wr = ex_ram_wr & i_en;

    // Forwarding sources and write-back mux
    // --------------------
    assign ex_src.we    = ex_wb_d.we;
    assign ex_src.rd    = ex_wb_d.rd;
    assign ex_src.value = ex_wb_d.result;

    assign wb_src.we    = wb_q.we;
    assign wb_src.rd    = wb_q.rd;
    assign wb_src.value = wb_q.from_mem ? i_ram_rdata : wb_q.result;

    assign rf_wr.we     = wb_q.we & i_en;
    assign rf_wr.rd     = wb_q.rd;
    assign rf_wr.value  = wb_src.value;

    // Pipeline registers and flags
    // --------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            id_vld  <= 1'b0;
            ex_q    <= '0;
            wb_q    <= '0;
            flags_q <= '0;
        end else if (i_en) begin
            if (stall) begin
                ex_q <= '0;
            end else begin
                // Word fetched behind a taken branch is dropped
                id_vld <= o_rom_en & ~redirect;
                ex_q   <= dec_d;
            end
            wb_q    <= ex_wb_d;
            flags_q <= flags_next;
        end
    end

endmodule

// ==== tb_arm_core.sv ====
`timescale 1ns/1ps
`include "arm_params.svh"

module tb_arm_core;

    localparam int MEM_WORDS  = 64;
    localparam int N_STORES   = 17;
    localparam int WAIT_LIMIT = 200;
    localparam int QUIET_CYC  = 20;

    typedef struct packed {
        logic [`ARM_XLEN-1:0] addr;
        logic [`ARM_XLEN-1:0] data;
    } store_t;

    logic                   clk;
    logic                   arst_n;
    logic                   en;
    logic                   rom_en;
    logic [`ARM_XLEN-1:0]   rom_addr;
    logic [`ARM_XLEN-1:0]   rom_data;
    logic                   ram_en;
    logic                   ram_wr;
    logic [`ARM_XLEN-1:0]   ram_addr;
    logic [`ARM_XLEN-1:0]   ram_rdata;
    logic [`ARM_XLEN-1:0]   ram_wdata;

    logic [`ARM_XLEN-1:0]   rom [MEM_WORDS];
    logic [`ARM_XLEN-1:0]   ram [MEM_WORDS];
    store_t                 stores [N_STORES];
    int                     n_stores;
    logic [1:0]             en_mode;
    logic [31:0]            lfsr;
    logic                   gap_bit0;
    logic                   gap_bit1;

    arm_core dut_i (
        .clk         (clk      ),
        .i_arst_n    (arst_n   ),
        .i_en        (en       ),
        .o_rom_en    (rom_en   ),
        .o_rom_addr  (rom_addr ),
        .i_rom_data  (rom_data ),
        .o_ram_en    (ram_en   ),
        .o_ram_wr    (ram_wr   ),
        .o_ram_addr  (ram_addr ),
        .i_ram_rdata (ram_rdata),
        .o_ram_wdata (ram_wdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [`ARM_XLEN-1:0] fill_word(input logic [`ARM_XLEN-1:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h1357_0000;
    endfunction

    // Memory models
    // --------------------
    always @(posedge clk) begin
        if (rom_en) begin
            rom_data <= rom[rom_addr[7:2]];
        end
    end

    // RAM contents come back to the fill pattern while reset is held
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int j = 0; j < MEM_WORDS; j++) begin
                ram[j] <= fill_word(j * 4);
            end
        end else if (ram_en) begin
            if (ram_wr) begin
                ram[ram_addr[7:2]] <= ram_wdata;
            end else begin
                ram_rdata <= ram[ram_addr[7:2]];
            end
        end
    end

    // Enable level 0 is low, 1 is high, 2 gives random single low cycles
    always @(posedge clk) begin
        case (en_mode)
            2'd1: en <= 1'b1;
            2'd2: begin
                if (!en) begin
                    en <= 1'b1;
                end else begin
                    gap_bit0 = lfsr[0];
                    lfsr     = lfsr_next(lfsr);
                    gap_bit1 = lfsr[0];
                    lfsr     = lfsr_next(lfsr);
                    en <= !(gap_bit0 && gap_bit1);
                end
            end
            default: en <= 1'b0;
        endcase
    end

    task automatic add_store(input logic [31:0] addr, input logic [31:0] data);
        stores[n_stores] = {addr, data};
        n_stores++;
    endtask

    // Program and expected stores
    // --------------------
    task automatic load_tables();
        for (int j = 0; j < MEM_WORDS; j++) begin
            rom[j] = 32'hf000_0000;
        end
        rom[0]  = 32'he3a0_1040;    // mov r1, #0x40
        rom[1]  = 32'he3a0_2005;    // mov r2, #5
        rom[2]  = 32'he282_3007;    // add r3, r2, #7
        rom[3]  = 32'he043_4002;    // sub r4, r3, r2
        rom[4]  = 32'he262_5014;    // rsb r5, r2, #20
        rom[5]  = 32'he203_600a;    // and r6, r3, #10
        rom[6]  = 32'he182_7006;    // orr r7, r2, r6
        rom[7]  = 32'he227_80ff;    // eor r8, r7, #0xff
        rom[8]  = 32'he1c8_9005;    // bic r9, r8, r5
        rom[9]  = 32'he3e0_a00f;    // mvn r10, #0xf
        rom[10] = 32'he3a0_b4ff;    // mov r11, #0xff000000
        rom[11] = 32'he581_b020;    // str r11, [r1, #32]
        rom[12] = 32'he581_3000;
        rom[13] = 32'he581_4004;
        rom[14] = 32'he581_5008;
        rom[15] = 32'he581_600c;
        rom[16] = 32'he581_7010;
        rom[17] = 32'he581_8014;
        rom[18] = 32'he581_9018;
        rom[19] = 32'he581_a01c;
        rom[20] = 32'he591_c080;    // ldr r12, [r1, #0x80]
        rom[21] = 32'he28c_c003;    // add r12, r12, #3
        rom[22] = 32'he581_c024;
        rom[23] = 32'he501_2004;    // str r2, [r1, #-4]
        rom[24] = 32'he352_0005;    // cmp r2, #5
        rom[25] = 32'h03a0_d001;    // moveq r13, #1
        rom[26] = 32'h13a0_d002;    // movne r13, #2
        rom[27] = 32'h23a0_e003;    // movcs r14, #3
        rom[28] = 32'he581_d028;
        rom[29] = 32'he581_e02c;
        rom[30] = 32'he252_0009;    // subs r0, r2, #9
        rom[31] = 32'h43a0_d004;    // movmi r13, #4
        rom[32] = 32'ha3a0_e005;    // movge r14, #5
        rom[33] = 32'hb3a0_e006;    // movlt r14, #6
        rom[34] = 32'h23a0_d007;    // movcs r13, #7
        rom[35] = 32'he581_d030;
        rom[36] = 32'he581_e034;
        rom[37] = 32'he581_0038;
        rom[38] = 32'hea00_0001;    // b to word 41
        rom[39] = 32'he581_203c;
        rom[40] = 32'he581_303c;
        rom[41] = 32'he352_0005;    // cmp r2, #5
        rom[42] = 32'h1aff_fffb;    // bne back to word 39 falls through
        rom[43] = 32'he581_503c;
        rom[44] = 32'heaff_fffe;    // b .

        n_stores = 0;
        add_store(32'h60, 32'hff00_0000);
        add_store(32'h40, 32'd12);
        add_store(32'h44, 32'd7);
        add_store(32'h48, 32'd15);
        add_store(32'h4c, 32'd8);
        add_store(32'h50, 32'd13);
        add_store(32'h54, 32'hf2);
        add_store(32'h58, 32'hf0);
        add_store(32'h5c, 32'hffff_fff0);
        add_store(32'h64, fill_word(32'hc0) + 32'd3);
        add_store(32'h3c, 32'd5);
        add_store(32'h68, 32'd1);
        add_store(32'h6c, 32'd3);
        add_store(32'h70, 32'd4);
        add_store(32'h74, 32'd6);
        add_store(32'h78, 32'hffff_fffc);
        add_store(32'h7c, 32'd15);
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic wait_first_fetch(input int pass);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!rom_en) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout in run %0d: the first ROM fetch never came", pass);
                $display("SIMULATION FAILED");
                $fatal(1, "no ROM fetch");
            end
            cycles++;
            @(negedge clk);
        end
        expect_equal("o_rom_addr", rom_addr, `ARM_PC_RESET);
    endtask

    task automatic wait_for_store(input int pass, input int k);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(ram_en && ram_wr)) begin
            if (cycles >= WAIT_LIMIT) begin
                $display("Timeout in run %0d: store %0d to address 0x%08h never came",
                         pass, k, stores[k].addr);
                $display("SIMULATION FAILED");
                $fatal(1, "missing store");
            end
            cycles++;
            @(negedge clk);
        end
        expect_equal("o_ram_addr", ram_addr, stores[k].addr);
        expect_equal("o_ram_wdata", ram_wdata, stores[k].data);
    endtask

    // Main sequence
    // --------------------
    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        en        = 1'b0;
        rom_data  = '0;
        ram_rdata = '0;
        en_mode   = 2'd0;
        lfsr      = 32'h5fd5_b107;
        load_tables();

        // Second run repeats the program with enable gaps
        for (int pass = 0; pass < 2; pass++) begin
            en_mode = 2'd0;
            apply_reset();
            repeat (3) begin
                @(negedge clk);
                expect_equal("o_rom_en", rom_en, 1'b0);
                expect_equal("o_ram_en", ram_en, 1'b0);
            end
            en_mode = (pass == 0) ? 2'd1 : 2'd2;
            wait_first_fetch(pass);
            for (int k = 0; k < N_STORES; k++) begin
                wait_for_store(pass, k);
            end
            // Skipped words and the final loop write nothing
            repeat (QUIET_CYC) begin
                @(negedge clk);
                expect_equal("o_ram_wr", ram_en && ram_wr, 1'b0);
            end
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
arm_pkg.sv
arm_fetch.sv
arm_regfile.sv
arm_decode.sv
arm_hazard_fwd.sv
arm_execute.sv
arm_core.sv
tb_arm_core.sv
